// File: tb.f
+incdir+include
source/pager_pkg.sv
source/window_pager.sv
source/dos_fsm.sv
source/stall_timer.sv
source/memory_pager.sv
verif/tb_clock.sv
verif/tb_memory_pager.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = tb_memory_pager
RTL_TOP    = memory_pager
FILELIST   = tb.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^Verification passed$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_memory_pager.sv
/*
 * memory pager testbench
 * directed tests for reset, port writes, window 0 priority
 * and DOS entry / exit with the Z80 clock stall
 */
`timescale 1ns/1ps
`include "pager_config.svh"

module tb_memory_pager;
	import pager_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_LEN  = 16;
	// rough per-test cycle budgets, summed for the watchdog
	localparam int RESET_TEST_LEN    = 4;
	localparam int FOLLOW_TEST_LEN   = 16;
	localparam int MAP4M_TEST_LEN    = 16;
	localparam int PRIORITY_TEST_LEN = 10;
	localparam int ENTRY_TEST_LEN    = 32; // stall loop may run 16
	localparam int EXIT_TEST_LEN     = 16;
	localparam int MARGIN_LEN        = 50;
	localparam int WATCHDOG_CYCLES   = RESET_LEN + RESET_TEST_LEN + FOLLOW_TEST_LEN +
		MAP4M_TEST_LEN + PRIORITY_TEST_LEN + ENTRY_TEST_LEN + EXIT_TEST_LEN + MARGIN_LEN;

	localparam logic [5:0] FOLLOW_LOW = 6'h2A; // window 1 register 0 page bits, xFF7 write

	logic        fclk, reset;
	logic        zpos, zneg;
	logic [15:0] za;
	logic [7:0]  zd;
	logic        mreq_n, m1_n, port_wr;
	logic        pager_off, in_nmi;
	logic        pent1m_rom, pent1m_ram0, pent1m_1m_on;
	logic [5:0]  pent1m_page;
	logic [7:0]  page0, page1, page2, page3;
	logic [3:0]  rom_sel;
	dos_state_t  dos;
	logic        dos_turn_on, dos_turn_off, zclk_stall;

	int          error_count;
	int          tests_run;
	int          tests_failed;
	int          errors_at_start; // error_count when the current test began
	logic [31:0] seed;

	tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_LEN)) tb_clock_i (
		.fclk  (fclk),
		.reset (reset)
	);

	memory_pager memory_pager_i (
		.fclk (fclk), .reset (reset), .zpos (zpos), .zneg (zneg),
		.za (za), .zd (zd), .mreq_n (mreq_n), .m1_n (m1_n), .port_wr (port_wr),
		.pager_off (pager_off), .in_nmi (in_nmi), .pent1m_rom (pent1m_rom),
		.pent1m_page (pent1m_page), .pent1m_ram0 (pent1m_ram0),
		.pent1m_1m_on (pent1m_1m_on), .page0 (page0), .page1 (page1),
		.page2 (page2), .page3 (page3), .rom_sel (rom_sel), .dos (dos),
		.dos_turn_on (dos_turn_on), .dos_turn_off (dos_turn_off),
		.zclk_stall (zclk_stall)
	);

	task automatic compare_page(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got 8'h%02h expected 8'h%02h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got 1'h%0h expected 1'h%0h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_dos(input string name, input dos_state_t got, input dos_state_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got 1'h%0h expected 1'h%0h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("FAIL %s: got 'h%0h expected 'h%0h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic start_test();
		errors_at_start = error_count;
		tests_run++;
	endtask

	task automatic finish_test(input string name);
		if (error_count == errors_at_start)
			$display("test %-16s ok", name);
		else
		begin
			tests_failed++;
			$display("test %-16s %0d errors", name, error_count - errors_at_start);
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge fclk);
		#1;
	endtask

	// xxF7 write, page shows two cycles after the write cycle
	task automatic write_port(input logic [1:0] win, input port_op_t op, input logic [7:0] data);
		za      = {win, (op == PORT_MAP_1M) ? 14'h0FF7 : 14'h07F7}; // a11 picks the port
		zd      = data;
		port_wr = 1'b1;
		next_cycle();
		port_wr = 1'b0;
		next_cycle();
	endtask

	// m1_n taken on zpos, then mreq_n high and low on two zneg strobes
	task automatic opcode_fetch(input logic [15:0] addr, input logic is_m1,
		output logic on_seen, output logic off_seen, output logic stall_seen);
		za     = addr;
		m1_n   = ~is_m1;
		mreq_n = 1'b1;
		zpos   = 1'b1;
		zneg   = 1'b0;
		next_cycle();
		zpos = 1'b0;
		zneg = 1'b1; // mreq_n still high on this edge
		next_cycle();
		mreq_n = 1'b0; // falls on the second zneg
		#2;
		on_seen    = dos_turn_on;
		off_seen   = dos_turn_off;
		stall_seen = zclk_stall;
		next_cycle();
		zneg   = 1'b0;
		mreq_n = 1'b1;
		m1_n   = 1'b1;
	endtask

	task automatic reset_values();
		start_test();
		compare_page("page0", page0, 8'h00);
		compare_page("page1", page1, 8'h00);
		compare_page("page2", page2, 8'h00);
		compare_page("page3", page3, 8'h00);
		for (int i = 0; i < `PAGER_WINDOWS; i++)
			compare_flag($sformatf("rom_sel[%0d]", i), rom_sel[i], 1'b1);
		compare_dos("dos", dos, DOS_OFF);
		compare_flag("zclk_stall", zclk_stall, 1'b0);
		finish_test("reset_values");
	endtask

	// window 1, register 0, ram with follow flag
	task automatic follow_join_1m();
		logic [5:0] low;
		logic [7:0] stored;
		logic [5:0] pg;
		low    = FOLLOW_LOW;
		stored = ~{2'b11, low}; // inverted, 11 on top
		start_test();
		pent1m_rom = 1'b0;
		write_port(2'd1, PORT_MAP_1M, {1'b1, 1'b1, low}); // follow, ram
		for (int i = 0; i < 4; i++)
		begin
			pg           = 6'(i * 21); // 00 15 2A 3F
			pent1m_page  = pg;
			pent1m_1m_on = 1'b1;
			next_cycle();
			compare_page("page1 1m on", page1, {stored[7:6], pg});
			compare_flag("rom_sel[1]", rom_sel[1], 1'b0);
			pent1m_1m_on = 1'b0;
			next_cycle();
			compare_page("page1 1m off", page1, {stored[7:3], pg[2:0]});
		end
		finish_test("follow_join_1m");
	endtask

	task automatic map_4m_random();
		logic [31:0] rnd;
		logic [7:0]  data;
		logic [7:0]  w1_stored; // window 1 register 0 from follow_join_1m
		logic [7:0]  w1_page;
		start_test();
		data         = 8'h00;
		w1_stored    = ~{2'b11, FOLLOW_LOW};
		w1_page      = {w1_stored[7:3], 3'h7}; // 128k join with page bits 7
		pent1m_1m_on = 1'b0;
		pent1m_page  = 6'h07;
		for (int i = 0; i < 3; i++)
		begin
			rnd  = $random(seed);
			data = rnd[7:0];
			write_port(2'd2, PORT_MAP_4M, data);
			compare_page("page2", page2, ~data);
			compare_flag("rom_sel[2]", rom_sel[2], 1'b0);
			compare_page("page0", page0, 8'h00); // untouched windows
			compare_page("page1", page1, w1_page);
			compare_page("page3", page3, 8'h00);
			compare_flag("rom_sel[0]", rom_sel[0], 1'b1);
			compare_flag("rom_sel[1]", rom_sel[1], 1'b0);
			compare_flag("rom_sel[3]", rom_sel[3], 1'b1);
		end
		pent1m_rom = 1'b1; // register 1 still holds reset ROM 0
		next_cycle();
		compare_page("page2 reg1", page2, 8'h00);
		compare_flag("rom_sel[2] reg1", rom_sel[2], 1'b1);
		pent1m_rom = 1'b0;
		next_cycle();
		compare_page("page2 reg0", page2, ~data);
		finish_test("map_4m_random");
	endtask

	task automatic window0_priority();
		start_test();
		write_port(2'd0, PORT_MAP_4M, 8'h5A); // stored A5, ram
		pager_off   = 1'b1;
		in_nmi      = 1'b1;
		pent1m_ram0 = 1'b1;
		next_cycle();
		compare_page("page0 off", page0, 8'hFF);
		compare_flag("rom_sel[0] off", rom_sel[0], 1'b1);
		compare_page("page3 off", page3, 8'hFF);
		compare_flag("rom_sel[3] off", rom_sel[3], 1'b1);
		pager_off = 1'b0;
		next_cycle();
		compare_page("page0 nmi", page0, `NMI_PAGE);
		compare_flag("rom_sel[0] nmi", rom_sel[0], 1'b0);
		in_nmi = 1'b0;
		next_cycle();
		compare_page("page0 ram0", page0, 8'h00);
		compare_flag("rom_sel[0] ram0", rom_sel[0], 1'b0);
		pent1m_ram0 = 1'b0;
		next_cycle();
		compare_page("page0 stored", page0, 8'hA5);
		finish_test("window0_priority");
	endtask

	// window 0, register 1 as ROM following dos
	task automatic dos_entry(output logic [7:0] rom_base);
		logic [5:0] low;
		logic       on_seen, off_seen, stall_seen;
		int         stall_len;
		low      = 6'h12;
		rom_base = ~{2'b11, low} & 8'hFE; // bit 0 comes from dos
		start_test();
		pent1m_rom = 1'b1;
		write_port(2'd0, PORT_MAP_1M, {1'b1, 1'b0, low});
		compare_page("page0 basic", page0, rom_base);
		compare_flag("rom_sel[0]", rom_sel[0], 1'b1);
		compare_dos("dos before", dos, DOS_OFF);
		opcode_fetch({2'b00, `DOS_ENTRY_HI, 8'h00}, 1'b1, on_seen, off_seen, stall_seen);
		compare_flag("dos_turn_on", on_seen, 1'b1);
		compare_flag("dos_turn_off", off_seen, 1'b0);
		compare_flag("zclk_stall turn-on cycle", stall_seen, 1'b1);
		compare_dos("dos after", dos, DOS_ON);
		stall_len = stall_seen ? 1 : 0;
		#2;
		while (zclk_stall === 1'b1 && stall_len < 16) // bounded wait
		begin
			stall_len++;
			next_cycle();
			#2;
		end
		next_cycle(); // back to the usual drive point
		compare_count("zclk_stall length", stall_len, `STALL_CYCLES + 1);
		compare_page("page0 dos", page0, rom_base | 8'h01);
		finish_test("dos_entry");
	endtask

	task automatic dos_exit(input logic [7:0] rom_base);
		logic on_seen, off_seen, stall_seen;
		start_test();
		opcode_fetch({2'b00, `DOS_ENTRY_HI, 8'h00}, 1'b0, on_seen, off_seen, stall_seen);
		compare_flag("dos_turn_on plain read", on_seen, 1'b0);
		compare_flag("dos_turn_off plain read", off_seen, 1'b0);
		compare_dos("dos plain read", dos, DOS_ON);
		write_port(2'd3, PORT_MAP_4M, 8'h3C); // window 3 reg1 to ram
		opcode_fetch(16'hC000, 1'b1, on_seen, off_seen, stall_seen);
		compare_flag("dos_turn_off", off_seen, 1'b1);
		compare_flag("dos_turn_on", on_seen, 1'b0);
		compare_flag("zclk_stall", stall_seen, 1'b0);
		compare_dos("dos after exit", dos, DOS_OFF);
		next_cycle();
		compare_page("page0 basic", page0, rom_base);
		finish_test("dos_exit");
	endtask

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog timeout, tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		logic [7:0] rom_base;
		zpos         = 1'b0;
		zneg         = 1'b0;
		za           = 16'h0000;
		zd           = 8'h00;
		mreq_n       = 1'b1;
		m1_n         = 1'b1;
		port_wr      = 1'b0;
		pager_off    = 1'b0;
		in_nmi       = 1'b0;
		pent1m_rom   = 1'b0;
		pent1m_page  = 6'h00;
		pent1m_ram0  = 1'b0;
		pent1m_1m_on = 1'b0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		seed         = 32'hd6bc_60eb;
		@(negedge reset);
		reset_values();
		follow_join_1m();
		map_4m_random();
		window0_priority();
		dos_entry(rom_base);
		dos_exit(rom_base);
		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
			error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: verif/tb_clock.sv
/*
 * testbench clock and reset
 * free running fclk and a synchronous reset held for the first cycles
 */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD       = 20, // ns
	parameter int RESET_CYCLES = 16
)(
	output logic fclk,
	output logic reset
);
	initial
	begin
		fclk = 1'b0;
		forever #(PERIOD / 2) fclk = ~fclk;
	end

	// release just after an edge, like every other input
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge fclk);
		#1 reset = 1'b0;
	end

endmodule

// File: source/memory_pager.sv
/*
 * memory pager top
 * four window pagers, the DOS level state machine and
 * the Z80 clock stall timer
 */
`timescale 1ns/1ps
`include "pager_config.svh"

module memory_pager (
	input  logic                  fclk,
	input  logic                  reset,
	input  logic                  zpos,         // z80 clock rising edge strobe
	input  logic                  zneg,         // z80 clock falling edge strobe
	input  logic [15:0]           za,
	input  logic [7:0]            zd,
	input  logic                  mreq_n,
	input  logic                  m1_n,
	input  logic                  port_wr,      // xxF7 write strobe
	input  logic                  pager_off,
	input  logic                  in_nmi,
	input  logic                  pent1m_rom,
	input  logic [5:0]            pent1m_page,
	input  logic                  pent1m_ram0,
	input  logic                  pent1m_1m_on,
	output logic [7:0]            page0,        // 0000-3FFF
	output logic [7:0]            page1,        // 4000-7FFF
	output logic [7:0]            page2,        // 8000-BFFF
	output logic [7:0]            page3,        // C000-FFFF
	output logic [3:0]            rom_sel,      // one bit per window
	output pager_pkg::dos_state_t dos,
	output logic                  dos_turn_on,
	output logic                  dos_turn_off,
	output logic                  zclk_stall
);
	logic [7:0]                win_page [`PAGER_WINDOWS];
	logic [`PAGER_WINDOWS-1:0] on_stb;  // per window dos entry fetch
	logic [`PAGER_WINDOWS-1:0] off_stb; // per window ram fetch

	for (genvar w = 0; w < `PAGER_WINDOWS; w++)
	begin : g_win
		window_pager #(
			.WINDOW (w)
		) window_pager_i (
			.fclk         (fclk),
			.reset        (reset),
			.zpos         (zpos),
			.zneg         (zneg),
			.za           (za),
			.zd           (zd),
			.mreq_n       (mreq_n),
			.m1_n         (m1_n),
			.port_wr      (port_wr),
			.pager_off    (pager_off),
			.in_nmi       (in_nmi),
			.pent1m_rom   (pent1m_rom),
			.pent1m_page  (pent1m_page),
			.pent1m_ram0  (pent1m_ram0),
			.pent1m_1m_on (pent1m_1m_on),
			.dos          (dos),
			.page         (win_page[w]),
			.rom_sel      (rom_sel[w]),
			.dos_on_stb   (on_stb[w]),
			.dos_off_stb  (off_stb[w])
		);
	end

	assign page0 = win_page[0];
	assign page1 = win_page[1];
	assign page2 = win_page[2];
	assign page3 = win_page[3];

	// only one window can match za at a time, OR is enough
	assign dos_turn_on  = |on_stb;
	assign dos_turn_off = |off_stb;

	dos_fsm dos_fsm_i (
		.fclk    (fclk),
		.reset   (reset),
		.on_stb  (dos_turn_on),
		.off_stb (dos_turn_off),
		.dos     (dos)
	);

	stall_timer stall_timer_i (
		.fclk  (fclk),
		.reset (reset),
		.start (dos_turn_on),
		.stall (zclk_stall)
	);

endmodule

// File: source/stall_timer.sv
/*
 * Z80 clock stall timer
 * holds the Z80 clock for a few fclk cycles after DOS turns on
 * so the ROM can supply the new opcode in time
 */
`timescale 1ns/1ps
`include "pager_config.svh"

module stall_timer (
	input  logic fclk,
	input  logic reset,
	input  logic start, // dos turn-on strobe
	output logic stall
);
	localparam int CNT_W = $clog2(`STALL_CYCLES + 1);

	logic [CNT_W-1:0] count; // remaining stall cycles after the start cycle

	// reload on start, restart if already running
	always_ff @(posedge fclk)
	begin
		if (reset)
			count <= '0;
		else if (start)
			count <= CNT_W'(`STALL_CYCLES);
		else if (count != '0)
			count <= count - 1'b1;
	end

	// start cycle itself already stalls
	assign stall = start || (count != '0);

endmodule

// File: source/dos_fsm.sv
/*
 * DOS level state machine
 * entered on a fetch from the DOS entry region,
 * left on any opcode fetch from RAM
 */
`timescale 1ns/1ps

module dos_fsm (
	input  logic                  fclk,
	input  logic                  reset,
	input  logic                  on_stb,  // OR of window turn-on strobes
	input  logic                  off_stb, // OR of window turn-off strobes
	output pager_pkg::dos_state_t dos
);
	import pager_pkg::*;

	dos_state_t state;
	dos_state_t state_next;

	// next state, turn-on wins when both strobes fire
	always_comb
	begin
		state_next = state;
		case (state)
			DOS_OFF:
			begin
				if (on_stb)
					state_next = DOS_ON;
			end
			DOS_ON:
			begin
				if (off_stb && !on_stb)
					state_next = DOS_OFF;
			end
			default:
			begin
				state_next = DOS_OFF;
			end
		endcase
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
			state <= DOS_OFF;
		else
			state <= state_next;
	end

	// fed back to the pagers for rom page bit 0
	assign dos = state;

endmodule

// File: source/window_pager.sv
/*
 * window pager
 * one 16 KB window: two page registers picked by the 7FFD ROM bit,
 * xxF7 port write decode, registered page / rom_sel output and
 * the opcode fetch strobes used for DOS entry and exit
 */
`timescale 1ns/1ps
`include "pager_config.svh"

module window_pager #(
	parameter int WINDOW = 0 // window number, 0 has the NMI and ram0 rules
)(
	input  logic                  fclk,
	input  logic                  reset,
	input  logic                  zpos,         // z80 clock rising edge strobe
	input  logic                  zneg,         // z80 clock falling edge strobe
	input  logic [15:0]           za,           // z80 address
	input  logic [7:0]            zd,           // z80 data, port write payload
	input  logic                  mreq_n,
	input  logic                  m1_n,
	input  logic                  port_wr,      // xxF7 write strobe
	input  logic                  pager_off,    // service ROM everywhere
	input  logic                  in_nmi,
	input  logic                  pent1m_rom,   // 7ffd d4, picks page register
	input  logic [5:0]            pent1m_page,  // 7ffd ram page bits
	input  logic                  pent1m_ram0,  // ram page 0 in window 0
	input  logic                  pent1m_1m_on, // 1 MB 7ffd addressing
	input  pager_pkg::dos_state_t dos,
	output logic [7:0]            page,
	output logic                  rom_sel,      // 1 = ROM, 0 = RAM
	output logic                  dos_on_stb,
	output logic                  dos_off_stb
);
	import pager_pkg::*;

	localparam logic [1:0] WIN_SEL = 2'(WINDOW);

	logic [7:0] pages [2];   // page registers, index is pent1m_rom
	logic [1:0] ram_map;     // 1 = ram, 0 = rom, per register
	logic [1:0] follow;      // page follows 7ffd (ram) or dos (rom)
	logic       m1_n_reg;    // m1_n sampled on zpos
	logic       mreq_n_reg;  // mreq_n sampled on zneg
	logic       win_hit;     // za selects this window
	logic       fetch_stb;   // opcode fetch begins in this window
	port_op_t   port_op;
	logic [7:0] sel_page;
	logic       sel_ram;
	logic       sel_follow;
	logic [7:0] next_page;
	logic       next_rom;

	assign win_hit = (za[15:14] == WIN_SEL);

	// port write decode, only the addressed window reacts
	always_comb
	begin
		port_op = PORT_NONE;
		if (port_wr && win_hit)
		begin
			if (za[11])
				port_op = PORT_MAP_1M; // xFF7
			else
				port_op = PORT_MAP_4M; // x7F7
		end
	end

	// page registers, reset maps ROM page 0 in both
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			pages[0] <= 8'h00;
			pages[1] <= 8'h00;
			ram_map  <= 2'b00;
			follow   <= 2'b00;
		end
		else
		begin
			case (port_op)
				PORT_MAP_1M:
				begin
					pages[pent1m_rom]   <= ~{2'b11, zd[5:0]}; // stored inverted
					ram_map[pent1m_rom] <= zd[6];
					follow[pent1m_rom]  <= zd[7];
				end
				PORT_MAP_4M:
				begin
					pages[pent1m_rom]   <= ~zd;
					ram_map[pent1m_rom] <= 1'b1; // 4M port always maps ram
					// follow flag kept, so 7ffd paging works across 4 MB
				end
				default: ;
			endcase
		end
	end

	assign sel_page   = pages[pent1m_rom];
	assign sel_ram    = ram_map[pent1m_rom];
	assign sel_follow = follow[pent1m_rom];

	// page selection by priority
	always_comb
	begin
		next_page = sel_page;
		next_rom  = ~sel_ram;
		if (pager_off)
		begin
			next_page = 8'hFF; // service rom in every window
			next_rom  = 1'b1;
		end
		else if ((WINDOW == 0) && in_nmi)
		begin
			next_page = `NMI_PAGE;
			next_rom  = 1'b0;
		end
		else if ((WINDOW == 0) && pent1m_ram0)
		begin
			next_page = 8'h00;
			next_rom  = 1'b0;
		end
		else if (sel_follow)
		begin
			if (sel_ram && pent1m_1m_on)
				next_page = {sel_page[7:6], pent1m_page};      // whole 1 MB from 7ffd
			else if (sel_ram)
				next_page = {sel_page[7:3], pent1m_page[2:0]}; // 128k style
			else
				next_page = {sel_page[7:1], (dos == DOS_ON)};  // basic or dos rom
		end
	end

	// registered page outputs
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			page    <= 8'h00;
			rom_sel <= 1'b1;
		end
		else
		begin
			page    <= next_page;
			rom_sel <= next_rom;
		end
	end

	// bus sampling for the fetch detector
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			m1_n_reg   <= 1'b1;
			mreq_n_reg <= 1'b1;
		end
		else
		begin
			if (zpos)
				m1_n_reg <= m1_n;
			if (zneg)
				mreq_n_reg <= mreq_n;
		end
	end

	// mreq_n falling during an M1 cycle in this window
	assign fetch_stb = zneg && win_hit && !m1_n_reg && mreq_n_reg && !mreq_n;

	// fetch from 3Dxx with dos rom mapped via register 1
	assign dos_on_stb = fetch_stb && (za[13:8] == `DOS_ENTRY_HI) && pent1m_rom &&
		follow[1] && !ram_map[1];

	assign dos_off_stb = fetch_stb && sel_ram; // any fetch from ram leaves dos

endmodule

// File: source/pager_pkg.sv
/*
 * pager types
 * DOS level state and the decoded opcode of a window port write
 */
package pager_pkg;

	// DOS level, also drives bit 0 of a ROM page in follow mode
	typedef enum logic
	{
		DOS_OFF = 1'b0,
		DOS_ON  = 1'b1
	} dos_state_t;

	// decoded xxF7 port write for one window
	//   PORT_MAP_1M is xFF7 (a11 high), page + ram/rom + follow flag
	//   PORT_MAP_4M is x7F7, full 8-bit RAM page, follow flag kept
	typedef enum logic [1:0]
	{
		PORT_NONE   = 2'd0,
		PORT_MAP_1M = 2'd1,
		PORT_MAP_4M = 2'd2
	} port_op_t;

endpackage

// File: include/pager_config.svh
/*
 * memory pager configuration
 * window count, DOS entry stall length, NMI page and the
 * address region whose opcode fetch turns DOS on
 */
`ifndef PAGER_CONFIG_SVH
`define PAGER_CONFIG_SVH

// four 16 KB windows cover the Z80 address space
`define PAGER_WINDOWS 4

// extra fclk cycles of Z80 clock stall after the DOS turn-on cycle
// the ROM needs this to put new data on the bus at 7 or 14 MHz
`define STALL_CYCLES 3

// last RAM page, mapped to window 0 while the NMI handler runs
`define NMI_PAGE 8'hFF

// address bits 13..8 of the DOS entry region (3Dxx)
`define DOS_ENTRY_HI 6'h3D

`endif
